// File: hdl/musicBoxPkg.sv
/*
 * Music box shared constants
 * Key debounce, tone mixing and DAC SPI frame settings,
 * plus the DAC frame layout used by the serializer
 */
package musicBoxPkg;

	// ----------------------------------------
	// Key inputs and debounce
	// ----------------------------------------
	localparam int NumKeys         = 6;  // Music keys, bee key comes on top
	localparam int DebounceDivider = 16; // Clocks per debounce tick
	localparam int DebounceTicks   = 4;  // Stable ticks before level flips

	// ----------------------------------------
	// Tone mixing and sample path
	// ----------------------------------------
	localparam int SampleDivider       = 24;    // Clocks per sample tick
	localparam logic [7:0] KeyLevel    = 8'd32; // One key square wave
	localparam logic [7:0] BeeLevel    = 8'd40; // Bee buzz amplitude
	localparam int VolumeShift         = 3;     // Mix times eight
	localparam int SampleWidth         = 12;    // DAC resolution
	localparam int FifoDepth           = 4;

	// ----------------------------------------
	// DAC SPI link
	// ----------------------------------------
	localparam logic [3:0] DacCmdWrite = 4'b0011; // Write and update
	localparam int FrameBits           = 16;
	localparam int SyncGapCycles       = 2;       // SYNC high between frames

	// Serializer FSM encodings
	localparam logic [1:0] SerIdle  = 2'd0;
	localparam logic [1:0] SerShift = 2'd1;
	localparam logic [1:0] SerGap   = 2'd2;

	// One DAC word, seen as fields or as the raw shift word
	typedef union packed {
		struct packed {
			logic [3:0]             ctrl;   // Command nibble, sent first
			logic [SampleWidth-1:0] sample;
		} fields;
		logic [FrameBits-1:0] raw;          // MSB first on DIN
	} dacFrameT;

endpackage

// File: hdl/keyDebouncer.sv
/*
 * Key debouncer
 * Cleans the six music keys and the bee key on a slow tick
 * and turns bee key presses into the bee mode toggle
 */
`timescale 1ns/1ps

module keyDebouncer (
	input  logic                             clock50Mhz,
	input  logic                             rstN,
	input  logic [musicBoxPkg::NumKeys-1:0]  musicKeysN, // Active low
	input  logic                             beeKeyN,    // Active low
	output logic [musicBoxPkg::NumKeys-1:0]  keysHeld,   // 1 = pressed
	output logic                             beeOn
);

	logic [$clog2(musicBoxPkg::DebounceDivider)-1:0] tickDiv;
	logic                                            debounceTick;
	logic [musicBoxPkg::NumKeys:0]                   syncStage1; // Pressed, bee on top
	logic [musicBoxPkg::NumKeys:0]                   syncStage2;
	logic [musicBoxPkg::NumKeys:0]                   cleanLevel;
	logic [$clog2(musicBoxPkg::DebounceTicks)-1:0]   stableCount [musicBoxPkg::NumKeys+1];
	logic                                            beePrev;

	assign debounceTick = (tickDiv == musicBoxPkg::DebounceDivider - 1);
	assign keysHeld     = cleanLevel[musicBoxPkg::NumKeys-1:0];

	// Slow tick divider
	always_ff @(posedge clock50Mhz) begin
		if (!rstN || debounceTick) begin
			tickDiv <= '0;
		end else begin
			tickDiv <= tickDiv + 1'b1;
		end
	end

	// Two flop sync, inverted so 1 means pressed
	always_ff @(posedge clock50Mhz) begin
		if (!rstN) begin
			syncStage1 <= '0; // All released
			syncStage2 <= '0;
		end else begin
			syncStage1 <= ~{beeKeyN, musicKeysN};
			syncStage2 <= syncStage1;
		end
	end

	// ----------------------------------------
	// Per input stable counters
	// ----------------------------------------
	always_ff @(posedge clock50Mhz) begin
		if (!rstN) begin
			cleanLevel <= '0;
			for (int i = 0; i <= musicBoxPkg::NumKeys; i++) begin
				stableCount[i] <= '0;
			end
		end else if (debounceTick) begin
			for (int i = 0; i <= musicBoxPkg::NumKeys; i++) begin
				if (syncStage2[i] == cleanLevel[i]) begin
					stableCount[i] <= '0; // Bounce back, start over
				end else if (stableCount[i] == musicBoxPkg::DebounceTicks - 1) begin
					cleanLevel[i]  <= syncStage2[i]; // Accept new level
					stableCount[i] <= '0;
				end else begin
					stableCount[i] <= stableCount[i] + 1'b1;
				end
			end
		end
	end

	// Bee mode flips on each clean press edge
	always_ff @(posedge clock50Mhz) begin
		if (!rstN) begin
			beePrev <= 1'b0;
			beeOn   <= 1'b0;
		end else begin
			beePrev <= cleanLevel[musicBoxPkg::NumKeys];
			if (cleanLevel[musicBoxPkg::NumKeys] && !beePrev) begin
				beeOn <= ~beeOn;
			end
		end
	end

endmodule

// File: hdl/toneMixer.sv
/*
 * Tone mixer
 * Builds one 12-bit sample per sample tick from the held keys
 * and the bee buzz, then holds it until the buffer takes it
 */
`timescale 1ns/1ps

module toneMixer (
	input  logic                                clock50Mhz,
	input  logic                                rstN,
	input  logic [musicBoxPkg::NumKeys-1:0]     keysHeld,
	input  logic                                beeOn,
	output logic                                sampleValid,
	output logic [musicBoxPkg::SampleWidth-1:0] sample,
	input  logic                                sampleReady
);

	logic [$clog2(musicBoxPkg::SampleDivider)-1:0] tickDiv;
	logic                                          sampleTick;
	logic                                          takeTick;    // Tick with nothing pending
	logic [musicBoxPkg::NumKeys:0]                 sampleIndex; // Bit 0 bee, bit i+1 key i
	logic [7:0]                                    mixSum;

	assign sampleTick = (tickDiv == musicBoxPkg::SampleDivider - 1);
	assign takeTick   = sampleTick && !sampleValid;

	// ----------------------------------------
	// Sample rate divider
	// ----------------------------------------
	always_ff @(posedge clock50Mhz) begin
		if (!rstN || sampleTick) begin
			tickDiv <= '0;
		end else begin
			tickDiv <= tickDiv + 1'b1;
		end
	end

	// Square waves from the index bits
	always_comb begin
		mixSum = '0;
		for (int i = 0; i < musicBoxPkg::NumKeys; i++) begin
			if (keysHeld[i] && sampleIndex[i+1]) begin
				mixSum = mixSum + musicBoxPkg::KeyLevel;
			end
		end
		if (beeOn && sampleIndex[0]) begin
			mixSum = mixSum + musicBoxPkg::BeeLevel; // Fastest toggle for the buzz
		end
	end

	// ----------------------------------------
	// Handshake and index
	// ----------------------------------------
	always_ff @(posedge clock50Mhz) begin
		if (!rstN) begin
			sampleValid <= 1'b0;
			sampleIndex <= '0;
		end else if (sampleValid) begin
			if (sampleReady) begin
				sampleValid <= 1'b0;
				sampleIndex <= sampleIndex + 1'b1; // Counts transfers only
			end
		end else if (takeTick) begin
			sampleValid <= 1'b1;
		end
	end

	// Scaled sample, frozen while pending
	always_ff @(posedge clock50Mhz) begin
		if (takeTick) begin
			sample <= {{(musicBoxPkg::SampleWidth - 8 - musicBoxPkg::VolumeShift){1'b0}},
				mixSum, {musicBoxPkg::VolumeShift{1'b0}}};
		end
	end

endmodule

// File: hdl/sampleFifo.sv
/*
 * Sample buffer
 * Small circular FIFO between the tone mixer and the DAC serializer
 */
`timescale 1ns/1ps

module sampleFifo (
	input  logic                                clock50Mhz,
	input  logic                                rstN,
	input  logic                                sampleValid,
	input  logic [musicBoxPkg::SampleWidth-1:0] sample,
	output logic                                sampleReady,
	output logic                                popValid,
	output logic [musicBoxPkg::SampleWidth-1:0] popSample,
	input  logic                                popReady
);

	logic [musicBoxPkg::SampleWidth-1:0]         mem [musicBoxPkg::FifoDepth];
	logic [$clog2(musicBoxPkg::FifoDepth)-1:0]   wrPtr;
	logic [$clog2(musicBoxPkg::FifoDepth)-1:0]   rdPtr;
	logic [$clog2(musicBoxPkg::FifoDepth+1)-1:0] fillCount;
	logic                                        doPush;
	logic                                        doPop;

	assign sampleReady = (fillCount != musicBoxPkg::FifoDepth); // Not full
	assign popValid    = (fillCount != '0);                     // Not empty
	assign popSample   = mem[rdPtr];
	assign doPush      = sampleValid && sampleReady;
	assign doPop       = popValid && popReady;

	// Storage
	always_ff @(posedge clock50Mhz) begin
		if (doPush) begin
			mem[wrPtr] <= sample;
		end
	end

	// ----------------------------------------
	// Pointers and occupancy
	// ----------------------------------------
	always_ff @(posedge clock50Mhz) begin
		if (!rstN) begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			fillCount <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1; // Depth is a power of two, wraps itself
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10:   fillCount <= fillCount + 1'b1;
				2'b01:   fillCount <= fillCount - 1'b1;
				default: fillCount <= fillCount; // Both or neither
			endcase
		end
	end

endmodule

// File: hdl/dacSerializer.sv
/*
 * DAC serializer
 * Pops one sample at a time and sends it as a 16-bit SPI frame,
 * command nibble first, with SCLK at half the system clock rate
 */
`timescale 1ns/1ps

module dacSerializer (
	input  logic                                clock50Mhz,
	input  logic                                rstN,
	input  logic                                popValid,
	input  logic [musicBoxPkg::SampleWidth-1:0] popSample,
	output logic                                popReady,
	output logic                                spiSclk,
	output logic                                spiSyncN,
	output logic                                spiDin
);

	musicBoxPkg::dacFrameT                           loadFrame;
	logic [1:0]                                      serState;
	logic [musicBoxPkg::FrameBits-1:0]               shiftWord; // Next bit at MSB
	logic [$clog2(musicBoxPkg::FrameBits)-1:0]       bitCount;
	logic                                            halfBit;   // 0 = SCLK high half

	// Pops only when idle so each frame takes one sample
	assign popReady = (serState == musicBoxPkg::SerIdle) && popValid;

	always_comb begin
		loadFrame.fields.ctrl   = musicBoxPkg::DacCmdWrite;
		loadFrame.fields.sample = popSample;
	end

	// Shift register loaded one bit ahead of DIN
	always_ff @(posedge clock50Mhz) begin
		if (popReady) begin
			shiftWord <= loadFrame.raw << 1;
		end else if (serState == musicBoxPkg::SerShift && halfBit) begin
			shiftWord <= shiftWord << 1;
		end
	end

	// ----------------------------------------
	// Frame FSM
	// ----------------------------------------
	always_ff @(posedge clock50Mhz) begin
		if (!rstN) begin
			serState <= musicBoxPkg::SerIdle;
			spiSyncN <= 1'b1;
			spiSclk  <= 1'b0;
			spiDin   <= 1'b0;
			bitCount <= '0;
			halfBit  <= 1'b0;
		end else begin
			case (serState)
				musicBoxPkg::SerIdle: begin
					if (popReady) begin
						serState <= musicBoxPkg::SerShift;
						spiSyncN <= 1'b0;
						spiSclk  <= 1'b1;
						spiDin   <= loadFrame.raw[musicBoxPkg::FrameBits-1]; // MSB out
						bitCount <= '0;
						halfBit  <= 1'b0;
					end
				end
				musicBoxPkg::SerShift: begin
					if (!halfBit) begin
						spiSclk <= 1'b0; // DAC latches DIN on this falling edge
						halfBit <= 1'b1;
					end else if (bitCount == musicBoxPkg::FrameBits - 1) begin
						serState <= musicBoxPkg::SerGap; // Last bit done
						spiSyncN <= 1'b1;
						spiDin   <= 1'b0;
						halfBit  <= 1'b0;
					end else begin
						bitCount <= bitCount + 1'b1;
						spiSclk  <= 1'b1;
						spiDin   <= shiftWord[musicBoxPkg::FrameBits-1];
						halfBit  <= 1'b0;
					end
				end
				musicBoxPkg::SerGap: begin
					// Idle pop cycle is the second SYNC high cycle of the gap
					serState <= musicBoxPkg::SerIdle;
				end
				default: serState <= musicBoxPkg::SerIdle;
			endcase
		end
	end

endmodule

// File: hdl/musicBoxTop.sv
/*
 * Music box audio path top
 * Keys to debouncer, tone mixer, sample buffer and DAC serializer
 */
`timescale 1ns/1ps

module musicBoxTop (
	input  logic                            clock50Mhz,
	input  logic                            rstN,
	input  logic [musicBoxPkg::NumKeys-1:0] musicKeysN, // Active low keys
	input  logic                            beeKeyN,
	output logic                            spiSclk,    // DAC SPI lines
	output logic                            spiSyncN,
	output logic                            spiDin,
	output logic                            beeModeOn   // Indicator
);

	// ----------------------------------------
	// Internal links
	// ----------------------------------------
	logic [musicBoxPkg::NumKeys-1:0]     keysHeld;
	logic                                beeOn;
	logic                                sampleValid; // Mixer to buffer
	logic [musicBoxPkg::SampleWidth-1:0] sample;
	logic                                sampleReady;
	logic                                popValid;    // Buffer to serializer
	logic [musicBoxPkg::SampleWidth-1:0] popSample;
	logic                                popReady;

	assign beeModeOn = beeOn;

	keyDebouncer debouncer (
		.clock50Mhz (clock50Mhz),
		.rstN       (rstN),
		.musicKeysN (musicKeysN),
		.beeKeyN    (beeKeyN),
		.keysHeld   (keysHeld),
		.beeOn      (beeOn)
	);

	// Producer
	toneMixer mixer (
		.clock50Mhz  (clock50Mhz),
		.rstN        (rstN),
		.keysHeld    (keysHeld),
		.beeOn       (beeOn),
		.sampleValid (sampleValid),
		.sample      (sample),
		.sampleReady (sampleReady)
	);

	sampleFifo sampleBuffer (
		.clock50Mhz  (clock50Mhz),
		.rstN        (rstN),
		.sampleValid (sampleValid),
		.sample      (sample),
		.sampleReady (sampleReady),
		.popValid    (popValid),
		.popSample   (popSample),
		.popReady    (popReady)
	);

	// Consumer, sets the real output rate
	dacSerializer serializer (
		.clock50Mhz (clock50Mhz),
		.rstN       (rstN),
		.popValid   (popValid),
		.popSample  (popSample),
		.popReady   (popReady),
		.spiSclk    (spiSclk),
		.spiSyncN   (spiSyncN),
		.spiDin     (spiDin)
	);

endmodule

// File: tests/musicBox_properties.sv
/*
 * Music box SPI and buffer checks
 * Bound into the DAC serializer and the sample buffer
 */
`timescale 1ns/1ps

module musicBoxProperties (
	input logic                                        clock50Mhz,
	input logic                                        rstN,
	input logic                                        spiSclk,
	input logic                                        spiSyncN,
	input logic                                        sampleValid, // Buffer push side
	input logic [musicBoxPkg::SampleWidth-1:0]         sample,
	input logic                                        sampleReady,
	input logic [$clog2(musicBoxPkg::FifoDepth)-1:0]   wrPtr,
	input logic [$clog2(musicBoxPkg::FifoDepth+1)-1:0] fillCount
);

	int         assertFails = 0;
	logic [5:0] syncLowCount; // Cycles SYNC has been low

	always_ff @(posedge clock50Mhz) begin
		if (!rstN || spiSyncN) begin
			syncLowCount <= '0;
		end else begin
			syncLowCount <= syncLowCount + 1'b1;
		end
	end

	// ----------------------------------------
	// SPI frame timing
	// ----------------------------------------
	frameLength: assert property (@(posedge clock50Mhz) disable iff (!rstN)
		$rose(spiSyncN) |-> syncLowCount == 2 * musicBoxPkg::FrameBits)
		else begin
			assertFails = assertFails + 1;
			$error("SYNC low period is not one full frame");
		end

	sclkIdleLow: assert property (@(posedge clock50Mhz) disable iff (!rstN)
		spiSyncN |-> !spiSclk)
		else begin
			assertFails = assertFails + 1;
			$error("SCLK high while SYNC is high");
		end

	// Buffer guards
	pushNotFull: assert property (@(posedge clock50Mhz) disable iff (!rstN)
		fillCount == musicBoxPkg::FifoDepth |=> $stable(wrPtr))
		else begin
			assertFails = assertFails + 1;
			$error("Push into a full buffer");
		end

	sampleHeld: assert property (@(posedge clock50Mhz) disable iff (!rstN)
		sampleValid && !sampleReady |=> sampleValid && $stable(sample))
		else begin
			assertFails = assertFails + 1;
			$error("Pending sample dropped or changed before transfer");
		end

endmodule

bind dacSerializer musicBoxProperties serializerChecks (
	.clock50Mhz  (clock50Mhz),
	.rstN        (rstN),
	.spiSclk     (spiSclk),
	.spiSyncN    (spiSyncN),
	.sampleValid (1'b0), // No push side here
	.sample      ('0),
	.sampleReady (1'b1),
	.wrPtr       ('0),
	.fillCount   ('0)
);

bind sampleFifo musicBoxProperties bufferChecks (
	.clock50Mhz  (clock50Mhz),
	.rstN        (rstN),
	.spiSclk     (1'b0), // SPI lines idle here
	.spiSyncN    (1'b1),
	.sampleValid (sampleValid),
	.sample      (sample),
	.sampleReady (sampleReady),
	.wrPtr       (wrPtr),
	.fillCount   (fillCount)
);

// File: tests/musicBoxTb.sv
/*
 * Music box testbench
 * Plays key masks and bee presses from the data file, captures the
 * DAC SPI frames and checks every sample against the tone rule
 */
`timescale 1ns/1ps

module musicBoxTb;

	localparam int MaxTests     = 16;
	localparam int SettleCycles = 300; // Debounce, full buffer and one frame
	localparam int FrameCycles  = 2 * musicBoxPkg::FrameBits + musicBoxPkg::SyncGapCycles;
	localparam int BeePulse     = 100; // Bee key held low this long

	logic                            clock50Mhz;
	logic                            rstN;
	logic [musicBoxPkg::NumKeys-1:0] musicKeysN;
	logic                            beeKeyN;
	logic                            spiSclk;
	logic                            spiSyncN;
	logic                            spiDin;
	logic                            beeModeOn;

	logic [15:0]                     testData [4*MaxTests]; // Four words per test
	int                              numTests;
	int                              timeoutLimit = 0;      // 0 until the data is read
	int                              cycleCount   = 0;
	int                              errorCount   = 0;
	int                              checkCount   = 0;
	logic [31:0]                     lfsrState;
	logic [musicBoxPkg::NumKeys-1:0] keysModel;             // Keys the model holds
	logic                            beeModel;
	int                              releaseOrder [$];

	// Captured frames with their index and start cycle
	musicBoxPkg::dacFrameT           frameQ [$];
	int                              frameIdxQ [$];
	int                              frameStartQ [$];
	musicBoxPkg::dacFrameT           capFrame;
	int                              capBits    = 0;
	int                              capStart   = 0;
	int                              frameCount = 0;
	logic                            prevSyncN  = 1'b1;
	logic                            prevSclk   = 1'b0;

	musicBoxTop DUT (
		.clock50Mhz (clock50Mhz),
		.rstN       (rstN),
		.musicKeysN (musicKeysN),
		.beeKeyN    (beeKeyN),
		.spiSclk    (spiSclk),
		.spiSyncN   (spiSyncN),
		.spiDin     (spiDin),
		.beeModeOn  (beeModeOn)
	);

	initial begin
		clock50Mhz = 1'b0;
		forever #2 clock50Mhz = ~clock50Mhz; // 4 ns period
	end

	// ----------------------------------------
	// Cycle counter, timeout and SPI capture
	// ----------------------------------------
	always @(negedge clock50Mhz) begin
		cycleCount = cycleCount + 1;
		if (timeoutLimit != 0 && cycleCount >= timeoutLimit) begin
			$display("Timeout after %0d cycles, no frames arrived in time", cycleCount);
			$display("SIMULATION FAILED");
			$finish;
		end else if (rstN) begin
			if (prevSyncN && !spiSyncN) begin
				capBits  = 0; // New frame
				capStart = cycleCount;
			end
			if (!spiSyncN && prevSclk && !spiSclk) begin // DAC latches here
				capFrame.raw = {capFrame.raw[musicBoxPkg::FrameBits-2:0], spiDin};
				capBits      = capBits + 1;
				if (capBits == musicBoxPkg::FrameBits) begin
					frameQ.push_back(capFrame);
					frameIdxQ.push_back(frameCount);
					frameStartQ.push_back(capStart);
					frameCount = frameCount + 1;
				end
			end
			prevSyncN = spiSyncN;
			prevSclk  = spiSclk;
		end
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] advanceLfsr(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	// Square-wave sum per key index bit plus bee on odd samples
	function automatic logic [musicBoxPkg::SampleWidth-1:0] expectedSample(input int idx,
			input logic [musicBoxPkg::NumKeys-1:0] keys, input logic bee);
		int mix;
		mix = 0;
		for (int i = 0; i < musicBoxPkg::NumKeys; i++) begin
			if (keys[i] && ((idx >> (i + 1)) & 1) != 0) begin
				mix = mix + musicBoxPkg::KeyLevel;
			end
		end
		if (bee && (idx & 1) != 0) begin
			mix = mix + musicBoxPkg::BeeLevel;
		end
		mix = (mix % 256) * (1 << musicBoxPkg::VolumeShift);
		return mix[musicBoxPkg::SampleWidth-1:0];
	endfunction

	// Tests up to the FF end marker, -1 if there is none
	function automatic int countTests();
		for (int t = 0; t < MaxTests; t++) begin
			if (testData[4*t] == 16'h00FF) begin
				return t;
			end
		end
		return -1;
	endfunction

	// Doubled sum of settle plus frames over every step
	function automatic int timeoutCycles(input int tests);
		int                              total;
		int                              steps;
		logic [musicBoxPkg::NumKeys-1:0] prevMask;
		logic [musicBoxPkg::NumKeys-1:0] mask;
		total    = 0;
		prevMask = '0;
		for (int t = 0; t < tests; t++) begin
			mask  = testData[4*t][musicBoxPkg::NumKeys-1:0];
			steps = $countones(prevMask & ~mask); // One step per released key
			if (steps == 0) begin
				steps = 1;
			end
			total    = total + steps * (SettleCycles + FrameCycles * int'(testData[4*t+2]));
			prevMask = mask;
		end
		return 2 * total;
	endfunction

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic checkSample(input logic [musicBoxPkg::SampleWidth-1:0] expected,
			input logic [musicBoxPkg::SampleWidth-1:0] actual, input string name);
		checkCount = checkCount + 1;
		if (actual !== expected) begin
			errorCount = errorCount + 1;
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkCtrl(input logic [3:0] expected, input logic [3:0] actual,
			input string name);
		checkCount = checkCount + 1;
		if (actual !== expected) begin
			errorCount = errorCount + 1;
			$display("[FAIL] t=%0t %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	task automatic checkBee(input logic expected, input logic actual);
		checkCount = checkCount + 1;
		if (actual !== expected) begin
			errorCount = errorCount + 1;
			$display("[FAIL] t=%0t beeModeOn expected %b got %b", $time, expected, actual);
		end
	endtask

	// Rotate through the keys, an LFSR bit of 1 releases the front one
	task automatic orderReleases(input logic [musicBoxPkg::NumKeys-1:0] mask);
		int pool [$];
		int key;
		releaseOrder.delete();
		for (int i = 0; i < musicBoxPkg::NumKeys; i++) begin
			if (mask[i]) begin
				pool.push_back(i);
			end
		end
		while (pool.size() > 0) begin
			key = pool.pop_front();
			if (lfsrState[0]) begin
				releaseOrder.push_back(key);
			end else begin
				pool.push_back(key);
			end
			lfsrState = advanceLfsr(lfsrState);
		end
	endtask

	// Drive the model keys, optional bee press, then check settled frames
	task automatic applyStep(input logic beePress, input int frames,
			output logic [musicBoxPkg::SampleWidth-1:0] peakSeen);
		int                                  changeCycle;
		int                                  checked;
		int                                  idx;
		int                                  start;
		musicBoxPkg::dacFrameT               frame;
		logic [musicBoxPkg::SampleWidth-1:0] expSample;
		@(posedge clock50Mhz);
		musicKeysN  <= ~keysModel;
		changeCycle = cycleCount;
		if (beePress) begin
			beeKeyN <= 1'b0;
			repeat (BeePulse) @(posedge clock50Mhz);
			beeKeyN  <= 1'b1;
			beeModel = ~beeModel;
		end
		peakSeen = '0;
		checked  = 0;
		while (checked < frames) begin
			if (frameQ.size() == 0) begin
				@(posedge clock50Mhz);
			end else begin
				frame = frameQ.pop_front();
				idx   = frameIdxQ.pop_front();
				start = frameStartQ.pop_front();
				if (start >= changeCycle + SettleCycles) begin // Older frames dropped
					expSample = expectedSample(idx, keysModel, beeModel);
					checkCtrl(musicBoxPkg::DacCmdWrite, frame.fields.ctrl,
						$sformatf("ctrl[%0d]", idx));
					checkSample(expSample, frame.fields.sample, $sformatf("sample[%0d]", idx));
					if (frame.fields.sample > peakSeen) begin
						peakSeen = frame.fields.sample;
					end
					checked = checked + 1;
				end
			end
		end
		@(negedge clock50Mhz);
		checkBee(beeModel, beeModeOn);
	endtask

	// One data line, releases split into single-key steps
	task automatic runTest(input int t);
		logic [musicBoxPkg::NumKeys-1:0]     target;
		logic                                beePress;
		int                                  frames;
		int                                  errorsBefore;
		int                                  stepCount;
		logic [musicBoxPkg::SampleWidth-1:0] peakExp;
		logic [musicBoxPkg::SampleWidth-1:0] peakSeen;
		target       = testData[4*t][musicBoxPkg::NumKeys-1:0];
		beePress     = testData[4*t+1][0];
		frames       = int'(testData[4*t+2]);
		peakExp      = testData[4*t+3][musicBoxPkg::SampleWidth-1:0];
		errorsBefore = errorCount;
		stepCount    = 0;
		orderReleases(keysModel & ~target);
		keysModel = keysModel | target; // New presses go with the first step
		if (releaseOrder.size() == 0) begin
			applyStep(beePress, frames, peakSeen);
			stepCount = 1;
		end else begin
			while (releaseOrder.size() > 0) begin
				keysModel[releaseOrder.pop_front()] = 1'b0;
				applyStep(beePress && stepCount == 0, frames, peakSeen);
				stepCount = stepCount + 1;
			end
		end
		checkSample(peakExp, peakSeen, "peakSample");
		$display("Test %0d keys %h bee press %0d, %0d step(s) of %0d frames: %s", t + 1,
			target, beePress, stepCount, frames, (errorCount == errorsBefore) ? "ok" : "errors");
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		int assertFails;
		rstN       = 1'b0;
		musicKeysN = '1; // All released
		beeKeyN    = 1'b1;
		lfsrState  = 32'hf397;
		keysModel  = '0;
		beeModel   = 1'b0;
		$readmemh("tests/musicBox_testdata.txt", testData);
		numTests = countTests();
		if (numTests < 0) begin
			$display("Data file is missing or has no end marker");
			$display("SIMULATION FAILED");
			$finish;
		end else begin
			timeoutLimit = timeoutCycles(numTests);
			repeat (2) @(posedge clock50Mhz);
			rstN <= 1'b1;
			for (int t = 0; t < numTests; t++) begin
				runTest(t);
			end
			assertFails = DUT.serializer.serializerChecks.assertFails +
				DUT.sampleBuffer.bufferChecks.assertFails;
			$display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
				numTests, checkCount, errorCount, assertFails);
			if (errorCount == 0 && assertFails == 0) begin
				$display("SIMULATION PASSED");
			end else begin
				$display("SIMULATION FAILED");
			end
			$finish;
		end
	end

endmodule

// File: tests/musicBox_testdata.txt
// Columns: key mask, bee press flag, frames to check, expected peak sample (all hex)
// Keys dropped from the mask are released one at a time; a key mask of FF ends the list
00 0 10 000
02 0 10 100
3F 0 80 600
3F 1 80 740
3F 1 80 600
00 0 08 000
FF 0 00 000

// File: sources.f
hdl/musicBoxPkg.sv
hdl/keyDebouncer.sv
hdl/toneMixer.sv
hdl/sampleFifo.sv
hdl/dacSerializer.sv
hdl/musicBoxTop.sv
tests/musicBox_properties.sv
tests/musicBoxTb.sv

// File: run.sh
#!/bin/sh
# Build and run the music box testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module musicBoxTb -o musicBoxSim

./obj_dir/musicBoxSim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "Run failed, see sim.log"
	exit 1
fi
echo "Run finished without failures"
